//--- design/loader_pkg.sv
package loader_pkg;

	// serial byte and instruction word sizes.
	localparam int byte_bits = 8;
	localparam int word_bits = 32;

	// program loader states.
	typedef enum logic [2:0] {
		read_size,
		read_word,
		store_word,
		done
	} loader_state_t;

	// uart receiver states.
	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

endpackage

//--- design/uart_rx.sv
`timescale 1ns/100ps

module uart_rx
	import loader_pkg::*;
#(
	parameter int clks_per_bit = 868
) (
	input logic clk,
	input logic reset,
	input logic rx,
	output logic [byte_bits-1:0] rx_byte,
	output logic rx_strobe,
	output logic frame_error
);

	localparam int cnt_bits = $clog2(clks_per_bit + 1);
	localparam int idx_bits = $clog2(byte_bits);
	localparam logic [cnt_bits-1:0] bit_end = cnt_bits'(clks_per_bit - 1);
	localparam logic [cnt_bits-1:0] half_end = cnt_bits'(clks_per_bit / 2 - 1);
	localparam logic [idx_bits-1:0] last_bit = idx_bits'(byte_bits - 1);

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic [cnt_bits-1:0] cnt;
	logic [idx_bits-1:0] bit_idx;
	logic [byte_bits-1:0] shift_reg;
	logic bit_tick;
	logic data_tick;
	logic stop_ok;

	assign bit_tick = (cnt == bit_end);
	assign data_tick = (state == rx_data) && bit_tick;
	assign stop_ok = (state == rx_stop) && bit_tick && rx_sync;

	// two-flop synchronizer for an idle-high line.
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= rx_idle;
			cnt <= '0;
			bit_idx <= '0;
			rx_strobe <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			rx_strobe <= 1'b0;
			frame_error <= 1'b0;
			case (state)
				rx_idle: begin
					// a low line left by a bad stop bit does not start a frame.
					if (rx_prev && !rx_sync) begin
						state <= rx_start;
						cnt <= '0;
					end
				end
				rx_start: begin
					if (cnt == half_end) begin
						cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? rx_idle : rx_data;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				rx_data: begin
					if (bit_tick) begin
						cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == last_bit) begin
							state <= rx_stop;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				rx_stop: begin
					if (bit_tick) begin
						cnt <= '0;
						state <= rx_idle;
						rx_strobe <= rx_sync;
						frame_error <= !rx_sync;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// lsb first.
	always_ff @(posedge clk) begin
		if (data_tick) begin
			shift_reg <= {rx_sync, shift_reg[byte_bits-1:1]};
		end
		if (stop_ok) begin
			rx_byte <= shift_reg;
		end
	end

endmodule

//--- design/byte_fifo.sv
`timescale 1ns/100ps

module byte_fifo
	import loader_pkg::*;
#(
	parameter int fifo_depth = 16
) (
	input logic clk,
	input logic reset,
	input logic [byte_bits-1:0] rx_byte,
	input logic rx_strobe,
	input logic byte_req,
	output logic byte_ready,
	output logic [byte_bits-1:0] byte_data,
	output logic fifo_overflow
);

	localparam int ptr_bits = $clog2(fifo_depth);

	logic [byte_bits-1:0] buffer [fifo_depth];
	logic [ptr_bits-1:0] wr_ptr;
	logic [ptr_bits-1:0] rd_ptr;
	logic [ptr_bits:0] count;
	logic full;
	logic push;
	logic pop;

	assign full = (count == (ptr_bits + 1)'(fifo_depth));
	assign push = rx_strobe && !full;
	assign pop = byte_req && byte_ready;
	assign byte_ready = (count != '0);
	assign byte_data = buffer[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			fifo_overflow <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
			// sticky until reset.
			if (rx_strobe && full) begin
				fifo_overflow <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			buffer[wr_ptr] <= rx_byte;
		end
	end

endmodule

//--- design/program_loader.sv
`timescale 1ns/100ps

module program_loader
	import loader_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic byte_ready,
	input logic [byte_bits-1:0] byte_data,
	input logic mem_ready,
	output logic byte_req,
	output logic mem_valid,
	output logic [word_bits-1:0] mem_addr,
	output logic [word_bits-1:0] mem_data,
	output logic completed
);

	localparam int idx_bits = $clog2(word_bits / byte_bits);
	localparam logic [idx_bits-1:0] last_idx = idx_bits'(word_bits / byte_bits - 1);

	loader_state_t state;
	logic [idx_bits-1:0] byte_idx;
	logic [word_bits-1:0] word_buf;
	logic [word_bits-1:0] word_next;
	logic [word_bits-1:0] prog_size;
	logic [word_bits-1:0] prog_addr;
	logic [word_bits-1:0] next_addr;
	logic take;
	logic last_byte;
	logic store_start;

	// arriving byte goes in at the top, so the first byte ends up lowest.
	assign word_next = {byte_data, word_buf[word_bits-1:byte_bits]};
	assign take = byte_req && byte_ready;
	assign last_byte = take && (byte_idx == last_idx);
	assign store_start = last_byte && (state == read_word);
	assign next_addr = prog_addr + word_bits'(4);
	assign completed = (state == done);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= read_size;
			byte_idx <= '0;
			prog_size <= '0;
			prog_addr <= '0;
			byte_req <= 1'b0;
			mem_valid <= 1'b0;
		end else begin
			case (state)
				read_size, read_word: begin
					byte_req <= 1'b1;
					if (take) begin
						byte_idx <= byte_idx + 1'b1;
					end
					if (last_byte) begin
						byte_idx <= '0;
						if (state == read_size) begin
							prog_size <= word_next;
							if (word_next == '0) begin
								state <= done;
								byte_req <= 1'b0;
							end else begin
								state <= read_word;
							end
						end else begin
							state <= store_word;
							byte_req <= 1'b0;
							mem_valid <= 1'b1;
						end
					end
				end
				store_word: begin
					if (mem_ready) begin
						mem_valid <= 1'b0;
						prog_addr <= next_addr;
						if (next_addr >= prog_size) begin
							state <= done;
						end else begin
							state <= read_word;
							byte_req <= 1'b1;
						end
					end
				end
				done: begin
					byte_req <= 1'b0;
				end
				default: state <= read_size;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			word_buf <= word_next;
		end
		if (store_start) begin
			mem_addr <= prog_addr;
			mem_data <= word_next;
		end
	end

endmodule

//--- design/inst_mem.sv
`timescale 1ns/100ps

module inst_mem
	import loader_pkg::*;
#(
	parameter int mem_words = 1024
) (
	input logic clk,
	input logic reset,
	input logic mem_valid,
	input logic [word_bits-1:0] mem_addr,
	input logic [word_bits-1:0] mem_data,
	input logic [word_bits-1:0] fetch_addr,
	output logic mem_ready,
	output logic [word_bits-1:0] fetch_data
);

	localparam int idx_bits = $clog2(mem_words);

	logic [word_bits-1:0] storage [mem_words];
	logic [idx_bits-1:0] wr_idx;
	logic [idx_bits-1:0] rd_idx;
	logic write_en;

	// byte address to word index with the upper bits dropped.
	assign wr_idx = mem_addr[idx_bits+1:2];
	assign rd_idx = fetch_addr[idx_bits+1:2];
	// no second ack while the request is still held.
	assign write_en = mem_valid && !mem_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_ready <= 1'b0;
		end else begin
			mem_ready <= write_en;
		end
	end

	always_ff @(posedge clk) begin
		if (write_en) begin
			storage[wr_idx] <= mem_data;
		end
		fetch_data <= storage[rd_idx];
	end

endmodule

//--- design/boot_loader_top.sv
`timescale 1ns/100ps

module boot_loader_top
	import loader_pkg::*;
#(
	parameter int clks_per_bit = 868,
	parameter int fifo_depth = 16,
	parameter int mem_words = 1024
) (
	input logic clk,
	input logic reset,
	input logic rx,
	input logic [word_bits-1:0] fetch_addr,
	output logic [word_bits-1:0] fetch_data,
	output logic completed,
	output logic frame_error,
	output logic fifo_overflow
);

	logic [byte_bits-1:0] rx_byte;
	logic rx_strobe;
	logic byte_ready;
	logic [byte_bits-1:0] byte_data;
	logic byte_req;
	logic mem_valid;
	logic [word_bits-1:0] mem_addr;
	logic [word_bits-1:0] mem_data;
	logic mem_ready;

	uart_rx #(
		.clks_per_bit(clks_per_bit)
	) u_uart_rx (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.rx_byte(rx_byte),
		.rx_strobe(rx_strobe),
		.frame_error(frame_error)
	);

	byte_fifo #(
		.fifo_depth(fifo_depth)
	) u_byte_fifo (
		.clk(clk),
		.reset(reset),
		.rx_byte(rx_byte),
		.rx_strobe(rx_strobe),
		.byte_req(byte_req),
		.byte_ready(byte_ready),
		.byte_data(byte_data),
		.fifo_overflow(fifo_overflow)
	);

	program_loader u_program_loader (
		.clk(clk),
		.reset(reset),
		.byte_ready(byte_ready),
		.byte_data(byte_data),
		.mem_ready(mem_ready),
		.byte_req(byte_req),
		.mem_valid(mem_valid),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.completed(completed)
	);

	inst_mem #(
		.mem_words(mem_words)
	) u_inst_mem (
		.clk(clk),
		.reset(reset),
		.mem_valid(mem_valid),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.fetch_addr(fetch_addr),
		.mem_ready(mem_ready),
		.fetch_data(fetch_data)
	);

endmodule

//--- tests/boot_loader_assertions.sv
`timescale 1ns/100ps

module boot_loader_assertions
	import loader_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic byte_req,
	input logic mem_valid,
	input logic mem_ready,
	input logic [word_bits-1:0] mem_addr,
	input logic completed
);

	int fail_count = 0;

	// write request held with a fixed address until acknowledged.
	write_held: assert property (@(posedge clk) disable iff (reset)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr))
	else begin
		fail_count = fail_count + 1;
		$error("mem_valid dropped or mem_addr changed before mem_ready");
	end

	no_req_in_store: assert property (@(posedge clk) disable iff (reset)
		mem_valid |-> !byte_req)
	else begin
		fail_count = fail_count + 1;
		$error("byte_req high during a memory write");
	end

	// completion is sticky.
	done_sticky: assert property (@(posedge clk) disable iff (reset)
		completed |=> completed)
	else begin
		fail_count = fail_count + 1;
		$error("completed fell without reset");
	end

endmodule

//--- tests/boot_loader_tb.sv
`timescale 1ns/100ps

module boot_loader_tb
	import loader_pkg::*;
();

	localparam int clks_per_bit = 8;
	localparam int fifo_depth = 4;
	localparam int mem_words = 64;
	localparam int done_timeout = 400 * clks_per_bit;
	localparam int event_timeout = 4 * clks_per_bit;

	logic clk;
	logic reset;
	logic rx;
	logic [word_bits-1:0] fetch_addr;
	logic [word_bits-1:0] fetch_data;
	logic completed;
	logic frame_error;
	logic fifo_overflow;

	int frame_errors = 0;
	int bad_frames_sent;
	logic done_seen;
	logic [word_bits-1:0] fetch_ptr;

	boot_loader_top #(
		.clks_per_bit(clks_per_bit),
		.fifo_depth(fifo_depth),
		.mem_words(mem_words)
	) DUT (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.fetch_addr(fetch_addr),
		.fetch_data(fetch_data),
		.completed(completed),
		.frame_error(frame_error),
		.fifo_overflow(fifo_overflow)
	);

	bind program_loader boot_loader_assertions loader_checks (
		.clk(clk),
		.reset(reset),
		.byte_req(byte_req),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.mem_addr(mem_addr),
		.completed(completed)
	);

	always #20 clk = ~clk;

	// frame_error is a single pulse.
	always @(posedge clk) begin
		if (frame_error) begin
			frame_errors = frame_errors + 1;
		end
	end

	always @(negedge clk) begin
		if (DUT.u_program_loader.loader_checks.fail_count != 0) begin
			fail_run("a bound assertion on the program loader failed");
		end
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected) begin
			$display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		done_seen = 1'b0;
		fetch_ptr = '0;
	endtask

	// start bit, data lsb first, stop bit, then two idle bits.
	task automatic send_frame(input logic [7:0] value, input logic stop_bit);
		logic [9:0] bits;
		bits = {stop_bit, value, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			rx = bits[i];
			repeat (clks_per_bit - 1) @(negedge clk);
		end
		@(negedge clk);
		rx = 1'b1;
		repeat (2 * clks_per_bit - 1) @(negedge clk);
	endtask

	task automatic wait_completed();
		int cycles;
		cycles = 0;
		while (!completed && cycles < done_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (!completed) begin
			fail_run("timeout while waiting for completed");
		end
		done_seen = 1'b1;
	endtask

	task automatic send_bad_frame(input logic [7:0] value);
		int start;
		int cycles;
		start = frame_errors;
		send_frame(value, 1'b0);
		cycles = 0;
		while (frame_errors == start && cycles < event_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (frame_errors == start) begin
			fail_run("frame_error did not pulse after a frame with a low stop bit");
		end
		bad_frames_sent++;
	endtask

	task automatic expect_overflow(input logic level);
		int cycles;
		cycles = 0;
		while (fifo_overflow !== level && cycles < event_timeout) begin
			@(negedge clk);
			cycles++;
		end
		check_value(32'(fifo_overflow), 32'(level), "fifo_overflow");
	endtask

	task automatic fetch_word(input logic [word_bits-1:0] addr,
			output logic [word_bits-1:0] word);
		@(negedge clk);
		fetch_addr = addr;
		@(negedge clk);
		word = fetch_data;
	endtask

	task automatic run_command(input string line);
		logic [7:0] cmd;
		logic [31:0] value;
		logic [word_bits-1:0] word;
		int code;
		cmd = line[0];
		code = $sscanf(line.substr(2, line.len() - 1), "%h", value);
		if (code != 1) begin
			fail_run($sformatf("bad line in test data: %s", line));
		end
		case (cmd)
			"S": begin
				if (!done_seen) begin
					check_value(32'(completed), 32'd0, "completed before program end");
				end
				send_frame(value[7:0], 1'b1);
			end
			"F": send_bad_frame(value[7:0]);
			"C": wait_completed();
			"R": apply_reset();
			"A": fetch_ptr = value;
			"P": fetch_word(value, word);
			"O": expect_overflow(value[0]);
			"X": begin
				fetch_word(fetch_ptr, word);
				check_value(word, value, $sformatf("memory word at %h", fetch_ptr));
				fetch_ptr = fetch_ptr + 4;
			end
			default: fail_run($sformatf("unknown command in test data: %s", line));
		endcase
	endtask

	initial begin
		int fd;
		int code;
		string line;
		clk = 1'b0;
		reset = 1'b1;
		rx = 1'b1;
		fetch_addr = '0;
		bad_frames_sent = 0;
		done_seen = 1'b0;
		fetch_ptr = '0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		fd = $fopen("tests/boot_testdata.txt", "r");
		if (fd == 0) begin
			fail_run("cannot open tests/boot_testdata.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			if (code > 0 && line.len() > 2 && line[0] != "#") begin
				run_command(line);
			end
		end
		$fclose(fd);

		check_value(32'(frame_errors), 32'(bad_frames_sent), "frame_error pulse count");
		if (DUT.u_program_loader.loader_checks.fail_count == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			fail_run("a bound assertion on the program loader failed");
		end
	end

endmodule

//--- tests/boot_testdata.txt
# command letter, then a hex value. S good byte, F byte with low stop bit, C wait completed,
# X expected word at next fetch address, A set fetch address, P fetch only, O overflow, R reset.
S 10
S 00
S 00
S 00
S 78
S 56
S 34
S 12
S ef
S be
F 55
S ad
S de
S 0d
S f0
S ad
S 0b
S 42
S 00
S fe
S ca
C 0
X 12345678
X deadbeef
X 0badf00d
X cafe0042
P 00000020
P 000000fc
A 00000000
X 12345678
X deadbeef
S 01
S 02
S 03
S 04
O 0
S 05
O 1
R 0
S 00
S 00
S 00
S 00
C 0
A 00000000
X 12345678

//--- files.f
design/loader_pkg.sv
design/uart_rx.sv
design/byte_fifo.sv
design/program_loader.sv
design/inst_mem.sv
design/boot_loader_top.sv
tests/boot_loader_assertions.sv
tests/boot_loader_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the boot loader testbench with Verilator.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module boot_loader_tb -o boot_loader_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/boot_loader_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi
exit 0
